//--- design/mpmem_pkg.sv
`default_nettype none

package mpmem_pkg;

  // ********************
  // Sizes
  // ********************

  localparam int DATA_W     = 32;
  localparam int NUM_RDPT   = 2;   // Read ports, one memory copy each
  localparam int NUM_VBNK   = 4;   // Banks per copy
  localparam int BIT_VBNK   = 2;
  localparam int NUM_VROW   = 64;  // Rows per bank
  localparam int BIT_VROW   = 6;
  localparam int BIT_ADDR   = 8;   // Bank index in low bits, row above it
  localparam int SRAM_DELAY = 2;   // Bank read latency

  // ********************
  // Request and response types
  // ********************

  // Write request as seen at the top ports
  typedef struct packed {
    logic                write;
    logic [BIT_ADDR-1:0] addr;
    logic [DATA_W-1:0]   bw;
    logic [DATA_W-1:0]   din;
  } mem_wr_t;

  // Read request, one per port
  typedef struct packed {
    logic                read;
    logic [BIT_ADDR-1:0] addr;
  } mem_rd_t;

  // Write after address split
  typedef struct packed {
    logic                write;
    logic [BIT_VBNK-1:0] bank;
    logic [BIT_VROW-1:0] row;
    logic [DATA_W-1:0]   bw;
    logic [DATA_W-1:0]   din;
  } bank_wr_t;

  // Read after address split
  typedef struct packed {
    logic                read;
    logic [BIT_VBNK-1:0] bank;
    logic [BIT_VROW-1:0] row;
  } bank_rd_t;

  typedef struct packed {
    logic              vld;
    logic [DATA_W-1:0] data;
  } rd_rsp_t;

endpackage

`default_nettype wire

//--- design/mpmem_req_in.sv
`default_nettype none

module mpmem_req_in (
  input  logic                                          vrd_clk,
  input  logic                                          rst_n,
  input  mpmem_pkg::mem_wr_t                            wr_req,
  input  mpmem_pkg::mem_rd_t  [mpmem_pkg::NUM_RDPT-1:0] rd_req,
  output mpmem_pkg::bank_wr_t                           wr_split,
  output mpmem_pkg::bank_rd_t [mpmem_pkg::NUM_RDPT-1:0] rd_split
);
  import mpmem_pkg::*;

  logic                wr_vld_q;
  logic [BIT_ADDR-1:0] wr_addr_q;
  logic [DATA_W-1:0]   wr_bw_q;
  logic [DATA_W-1:0]   wr_din_q;

  logic [NUM_RDPT-1:0] rd_vld_q;
  logic [BIT_ADDR-1:0] rd_addr_q [NUM_RDPT];

  // ********************
  // Input flops
  // ********************

  always_ff @(posedge vrd_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_vld_q <= 1'b0;
      rd_vld_q <= '0;
    end else begin
      wr_vld_q <= wr_req.write;
      for (int p = 0; p < NUM_RDPT; p++) begin
        rd_vld_q[p] <= rd_req[p].read;
      end
    end
  end

  always_ff @(posedge vrd_clk) begin
    wr_addr_q <= wr_req.addr;
    wr_bw_q   <= wr_req.bw;
    wr_din_q  <= wr_req.din;
    for (int p = 0; p < NUM_RDPT; p++) begin
      rd_addr_q[p] <= rd_req[p].addr;
    end
  end

  // ********************
  // Address split
  // ********************

  always_comb begin
    wr_split.write = wr_vld_q;
    wr_split.bank  = wr_addr_q[BIT_VBNK-1:0];         // Low bits pick the bank
    wr_split.row   = wr_addr_q[BIT_ADDR-1:BIT_VBNK];
    wr_split.bw    = wr_bw_q;
    wr_split.din   = wr_din_q;
  end

  always_comb begin
    for (int p = 0; p < NUM_RDPT; p++) begin
      rd_split[p].read = rd_vld_q[p];
      rd_split[p].bank = rd_addr_q[p][BIT_VBNK-1:0];
      rd_split[p].row  = rd_addr_q[p][BIT_ADDR-1:BIT_VBNK];
    end
  end

endmodule

`default_nettype wire

//--- design/mpmem_bank_sram.sv
`default_nettype none

module mpmem_bank_sram (
  input  logic                           vrd_clk,
  input  logic                           write,
  input  logic [mpmem_pkg::BIT_VROW-1:0] wr_row,
  input  logic [mpmem_pkg::DATA_W-1:0]   bw,
  input  logic [mpmem_pkg::DATA_W-1:0]   din,
  input  logic                           read,
  input  logic [mpmem_pkg::BIT_VROW-1:0] rd_row,
  output logic [mpmem_pkg::DATA_W-1:0]   dout
);
  import mpmem_pkg::*;

  logic [DATA_W-1:0] mem [NUM_VROW];

  // Stage 0 is the array read, the rest model the output pipe
  logic [DATA_W-1:0] rd_pipe [SRAM_DELAY];

  // ********************
  // Masked write
  // ********************

  always_ff @(posedge vrd_clk) begin
    if (write) begin
      mem[wr_row] <= (mem[wr_row] & ~bw) | (din & bw);
    end
  end

  // ********************
  // Read pipeline
  // ********************

  // Array read on the same edge as a write sees the old word
  always_ff @(posedge vrd_clk) begin
    if (read) begin
      rd_pipe[0] <= mem[rd_row];
    end
    for (int s = 1; s < SRAM_DELAY; s++) begin
      rd_pipe[s] <= rd_pipe[s-1];
    end
  end

  assign dout = rd_pipe[SRAM_DELAY-1];

endmodule

`default_nettype wire

//--- design/mpmem_dup_core.sv
`default_nettype none

module mpmem_dup_core (
  input  logic                                          vrd_clk,
  input  logic                                          rst_n,
  input  mpmem_pkg::bank_wr_t                           wr_split,
  input  mpmem_pkg::bank_rd_t [mpmem_pkg::NUM_RDPT-1:0] rd_split,
  output mpmem_pkg::rd_rsp_t  [mpmem_pkg::NUM_RDPT-1:0] rd_rsp
);
  import mpmem_pkg::*;

  logic [NUM_VBNK-1:0]   bank_we;                           // Shared by all copies
  logic [DATA_W-1:0]     bank_dout [NUM_RDPT][NUM_VBNK];

  logic [SRAM_DELAY-1:0] vld_pipe  [NUM_RDPT];
  logic [BIT_VBNK-1:0]   bank_pipe [NUM_RDPT][SRAM_DELAY];

  // ********************
  // Write fan-out
  // ********************

  always_comb begin
    bank_we = '0;
    if (wr_split.write) begin
      bank_we[wr_split.bank] = 1'b1;
    end
  end

  // ********************
  // Bank arrays
  // ********************

  // One full copy per read port
  for (genvar p = 0; p < NUM_RDPT; p++) begin : g_copy
    for (genvar b = 0; b < NUM_VBNK; b++) begin : g_bank
      mpmem_bank_sram u_bank (
        .vrd_clk (vrd_clk),
        .write   (bank_we[b]),
        .wr_row  (wr_split.row),
        .bw      (wr_split.bw),
        .din     (wr_split.din),
        .read    (rd_split[p].read),   // Whole copy is read, bank picked later
        .rd_row  (rd_split[p].row),
        .dout    (bank_dout[p][b])
      );
    end
  end

  // ********************
  // Read tracking
  // ********************

  always_ff @(posedge vrd_clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int p = 0; p < NUM_RDPT; p++) begin
        vld_pipe[p] <= '0;
      end
    end else begin
      for (int p = 0; p < NUM_RDPT; p++) begin
        vld_pipe[p][0] <= rd_split[p].read;
        for (int s = 1; s < SRAM_DELAY; s++) begin
          vld_pipe[p][s] <= vld_pipe[p][s-1];
        end
      end
    end
  end

  // Bank index follows the strobe
  always_ff @(posedge vrd_clk) begin
    for (int p = 0; p < NUM_RDPT; p++) begin
      bank_pipe[p][0] <= rd_split[p].bank;
      for (int s = 1; s < SRAM_DELAY; s++) begin
        bank_pipe[p][s] <= bank_pipe[p][s-1];
      end
    end
  end

  // ********************
  // Response select
  // ********************

  always_comb begin
    for (int p = 0; p < NUM_RDPT; p++) begin
      rd_rsp[p].vld  = vld_pipe[p][SRAM_DELAY-1];
      rd_rsp[p].data = bank_dout[p][bank_pipe[p][SRAM_DELAY-1]];
    end
  end

endmodule

`default_nettype wire

//--- design/mpmem_rd_out.sv
`default_nettype none

module mpmem_rd_out (
  input  logic                                         vrd_clk,
  input  logic                                         rst_n,
  input  logic                                         flop_bypass,
  input  mpmem_pkg::rd_rsp_t [mpmem_pkg::NUM_RDPT-1:0] rsp_in,
  output mpmem_pkg::rd_rsp_t [mpmem_pkg::NUM_RDPT-1:0] rsp_out
);
  import mpmem_pkg::*;

  logic [NUM_RDPT-1:0] vld_q;
  logic [DATA_W-1:0]   data_q [NUM_RDPT];

  always_ff @(posedge vrd_clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q <= '0;
    end else begin
      for (int p = 0; p < NUM_RDPT; p++) begin
        vld_q[p] <= rsp_in[p].vld;
      end
    end
  end

  always_ff @(posedge vrd_clk) begin
    for (int p = 0; p < NUM_RDPT; p++) begin
      if (rsp_in[p].vld) begin
        data_q[p] <= rsp_in[p].data;  // Hold between responses
      end
    end
  end

  // Bypass is static during traffic
  always_comb begin
    for (int p = 0; p < NUM_RDPT; p++) begin
      if (flop_bypass) begin
        rsp_out[p] = rsp_in[p];
      end else begin
        rsp_out[p].vld  = vld_q[p];
        rsp_out[p].data = data_q[p];
      end
    end
  end

endmodule

`default_nettype wire

//--- design/mpmem_top.sv
`default_nettype none

module mpmem_top (
  input  logic                                          vrd_clk,
  input  logic                                          rst_n,
  input  logic                                          flop_bypass,
  input  mpmem_pkg::mem_wr_t                            wr_req,
  input  mpmem_pkg::mem_rd_t  [mpmem_pkg::NUM_RDPT-1:0] rd_req,
  output mpmem_pkg::rd_rsp_t  [mpmem_pkg::NUM_RDPT-1:0] rd_rsp
);
  import mpmem_pkg::*;

  bank_wr_t                wr_split;
  bank_rd_t [NUM_RDPT-1:0] rd_split;
  rd_rsp_t  [NUM_RDPT-1:0] core_rsp;   // Before the optional output flop

  // ********************
  // Input side
  // ********************

  mpmem_req_in u_req_in (
    .vrd_clk  (vrd_clk),
    .rst_n    (rst_n),
    .wr_req   (wr_req),
    .rd_req   (rd_req),
    .wr_split (wr_split),
    .rd_split (rd_split)
  );

  // ********************
  // Duplicated banks
  // ********************

  mpmem_dup_core u_core (
    .vrd_clk  (vrd_clk),
    .rst_n    (rst_n),
    .wr_split (wr_split),
    .rd_split (rd_split),
    .rd_rsp   (core_rsp)
  );

  // ********************
  // Output side
  // ********************

  mpmem_rd_out u_rd_out (
    .vrd_clk     (vrd_clk),
    .rst_n       (rst_n),
    .flop_bypass (flop_bypass),
    .rsp_in      (core_rsp),
    .rsp_out     (rd_rsp)
  );

endmodule

`default_nettype wire

//--- tb/mpmem_assert.sv
`default_nettype none

module mpmem_assert (
  input logic                                         vrd_clk,
  input logic                                         rst_n,
  input logic                                         flop_bypass,
  input mpmem_pkg::mem_rd_t [mpmem_pkg::NUM_RDPT-1:0] rd_req,
  input mpmem_pkg::rd_rsp_t [mpmem_pkg::NUM_RDPT-1:0] rd_rsp
);
  import mpmem_pkg::*;

  // ********************
  // Per-port checks
  // ********************

  for (genvar p = 0; p < NUM_RDPT; p++) begin : g_port
    a_rst_quiet : assert property (@(posedge vrd_clk) !rst_n |-> !rd_rsp[p].vld)
      else $error("Port %0d valid while in reset", p);

    // Pass-through output, 3 cycles from request
    a_lat_bypass : assert property (@(posedge vrd_clk) disable iff (!rst_n)
      flop_bypass |-> rd_rsp[p].vld == $past(rd_req[p].read, 3))
      else $error("Port %0d valid not 3 cycles after read", p);

    a_lat_flop : assert property (@(posedge vrd_clk) disable iff (!rst_n)
      !flop_bypass |-> rd_rsp[p].vld == $past(rd_req[p].read, 4))
      else $error("Port %0d valid not 4 cycles after read", p);
  end

endmodule

bind mpmem_top mpmem_assert u_assert (
  .vrd_clk     (vrd_clk),
  .rst_n       (rst_n),
  .flop_bypass (flop_bypass),
  .rd_req      (rd_req),
  .rd_rsp      (rd_rsp)
);

`default_nettype wire

//--- tb/mpmem_tb.sv
`default_nettype none

module mpmem_tb;
  import mpmem_pkg::*;

  localparam logic OP_NOP = 1'b0;
  localparam logic OP_WR  = 1'b1;

  localparam logic [BIT_ADDR-1:0] FULL_ADDRS [6] = '{8'h00, 8'h05, 8'h0a, 8'h0f, 8'h13, 8'hfe};

  // One row is applied per clock
  typedef struct packed {
    logic                op;
    logic [BIT_ADDR-1:0] waddr;
    logic [DATA_W-1:0]   mask;
    logic                rnd;     // Random data, else address pattern
    logic                re0;
    logic [BIT_ADDR-1:0] ra0;
    logic                re1;
    logic [BIT_ADDR-1:0] ra1;
    logic                byp;
  } row_t;

  typedef struct packed {
    logic [31:0]       due;       // Edge count when vld is expected
    logic [DATA_W-1:0] data;
  } exp_t;

  logic                        vrd_clk;
  logic                        rst_n;
  logic                        flop_bypass;
  mem_wr_t                     wr_req;
  mem_rd_t  [NUM_RDPT-1:0]     rd_req;
  rd_rsp_t  [NUM_RDPT-1:0]     rd_rsp;

  row_t              rows [$];
  logic [DATA_W-1:0] ref_mem [1 << BIT_ADDR];
  exp_t              exp_q [NUM_RDPT][$];
  logic [31:0]       lcg_state = 32'h00d90c21;
  logic [31:0]       edge_cnt = '0;
  int                num_rows = 0;
  int                err_val = 0;
  int                err_miss = 0;
  int                err_unexp = 0;

  mpmem_top UUT (
    .vrd_clk     (vrd_clk),
    .rst_n       (rst_n),
    .flop_bypass (flop_bypass),
    .wr_req      (wr_req),
    .rd_req      (rd_req),
    .rd_rsp      (rd_rsp)
  );

  always #10 vrd_clk = ~vrd_clk;

  always @(posedge vrd_clk) edge_cnt <= edge_cnt + 32'd1;

  // ********************
  // Helpers
  // ********************

  function automatic logic [DATA_W-1:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [DATA_W-1:0] addr_pattern(input logic [BIT_ADDR-1:0] a);
    return {a, ~a, a ^ 8'h5a, 8'hc3 ^ {a[3:0], a[7:4]}};
  endfunction

  task automatic compare_value(input string name, input logic [DATA_W-1:0] actual,
                               input logic [DATA_W-1:0] expected);
    if (actual !== expected) begin
      err_val++;
      $display("FAILED at %0t: %s = %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic add_row(input logic op, input logic [BIT_ADDR-1:0] waddr,
                         input logic [DATA_W-1:0] mask, input logic rnd,
                         input logic re0, input logic [BIT_ADDR-1:0] ra0,
                         input logic re1, input logic [BIT_ADDR-1:0] ra1, input logic byp);
    rows.push_back(row_t'{op, waddr, mask, rnd, re0, ra0, re1, ra1, byp});
  endtask

  // Full write payload with the strobe low
  task automatic idle_rows(input int n, input logic byp);
    repeat (n) add_row(OP_NOP, 8'h00, '1, 1'b1, 1'b0, 8'h00, 1'b0, 8'h00, byp);
  endtask

  // ********************
  // Stimulus table
  // ********************

  task automatic build_table();
    idle_rows(4, 1'b1);                          // Quiet after reset
    for (int i = 0; i < 6; i++) begin
      add_row(OP_WR, FULL_ADDRS[i], '1, i[0], 1'b0, 8'h00, 1'b0, 8'h00, 1'b1);
    end
    // Port 1 walks the list backwards
    for (int i = 0; i < 6; i++) begin
      add_row(OP_NOP, 8'h00, '0, 1'b0, 1'b1, FULL_ADDRS[i], 1'b1, FULL_ADDRS[5-i], 1'b1);
    end
    add_row(OP_WR, 8'h05, 32'h0000ffff, 1'b1, 1'b0, 8'h00, 1'b0, 8'h00, 1'b1);
    add_row(OP_WR, 8'h0a, 32'hf0f00f0f, 1'b1, 1'b1, 8'h05, 1'b0, 8'h00, 1'b1);
    add_row(OP_NOP, 8'h00, '0, 1'b0, 1'b1, 8'h0a, 1'b1, 8'h05, 1'b1);
    // Same-cycle read of the written word, then the new value
    add_row(OP_WR, 8'h13, '1, 1'b1, 1'b1, 8'h13, 1'b1, 8'h00, 1'b1);
    add_row(OP_NOP, 8'h00, '0, 1'b0, 1'b1, 8'hfe, 1'b1, 8'h13, 1'b1);
    idle_rows(4, 1'b1);
    for (int i = 0; i < 10; i++) begin
      add_row(OP_WR, 8'(8'h40 + i), '1, 1'b1,
              1'b1, (i == 0) ? 8'h00 : 8'(8'h3f + i),
              1'b1, (i < 2) ? 8'h0f : 8'(8'h3e + i), 1'b1);
    end
    idle_rows(4, 1'b1);                          // Drain before bypass changes
    idle_rows(2, 1'b0);
    for (int i = 0; i < 10; i++) begin
      add_row(OP_WR, 8'(8'h40 + ((i + 1) % 10)), 32'hff00ff00, 1'b1,
              1'b1, 8'(8'h40 + i), 1'b1, 8'(8'h49 - i), 1'b0);
    end
    add_row(OP_WR, 8'hfe, 32'h00ffff00, 1'b1, 1'b1, 8'hfe, 1'b1, 8'h0a, 1'b0);
    add_row(OP_NOP, 8'h00, '0, 1'b0, 1'b1, 8'h13, 1'b1, 8'hfe, 1'b0);
    idle_rows(6, 1'b0);
  endtask

  // ********************
  // Drive and model
  // ********************

  initial begin
    row_t              r;
    logic [DATA_W-1:0] wdata;
    int                lat;

    vrd_clk     = 1'b0;
    rst_n       = 1'b1;
    flop_bypass = 1'b1;
    wr_req      = '0;
    rd_req      = '0;
    build_table();
    num_rows = rows.size();
    #1 rst_n = 1'b0;
    repeat (3) @(posedge vrd_clk);
    rst_n <= 1'b1;

    for (int i = 0; i < num_rows; i++) begin
      @(posedge vrd_clk);
      r     = rows[i];
      lat   = r.byp ? 3 : 4;
      wdata = r.rnd ? next_random() : addr_pattern(r.waddr);
      // Reads see the memory before this row's write
      if (r.re0) exp_q[0].push_back(exp_t'{edge_cnt + 32'd1 + lat, ref_mem[r.ra0]});
      if (r.re1) exp_q[1].push_back(exp_t'{edge_cnt + 32'd1 + lat, ref_mem[r.ra1]});
      if (r.op == OP_WR) begin
        ref_mem[r.waddr] = (ref_mem[r.waddr] & ~r.mask) | (wdata & r.mask);
      end
      flop_bypass <= r.byp;
      wr_req      <= mem_wr_t'{r.op, r.waddr, r.mask, wdata};
      rd_req[0]   <= mem_rd_t'{r.re0, r.ra0};
      rd_req[1]   <= mem_rd_t'{r.re1, r.ra1};
    end

    while (exp_q[0].size() != 0 || exp_q[1].size() != 0) @(posedge vrd_clk);
    repeat (2) @(posedge vrd_clk);              // Catch late strays

    $display("Checks done: %0d data errors, %0d missing responses, %0d unexpected responses",
             err_val, err_miss, err_unexp);
    if (err_val == 0 && err_miss == 0 && err_unexp == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // ********************
  // Response monitor
  // ********************

  always @(negedge vrd_clk) begin
    for (int p = 0; p < NUM_RDPT; p++) begin
      if (rst_n && exp_q[p].size() != 0 && exp_q[p][0].due == edge_cnt) begin
        if (rd_rsp[p].vld) begin
          compare_value($sformatf("rd_rsp[%0d].data", p), rd_rsp[p].data, exp_q[p][0].data);
        end else begin
          err_miss++;
          $display("Read response on port %0d missing at %0t", p, $time);
        end
        void'(exp_q[p].pop_front());
      end else if (rd_rsp[p].vld) begin
        err_unexp++;
        $display("Read response on port %0d at %0t with no read due", p, $time);
      end
    end
  end

  initial begin
    wait (num_rows > 0);
    #((num_rows + 20) * 20);
    $display("Timeout: run did not finish within %0d clock cycles", num_rows + 20);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
design/mpmem_pkg.sv
design/mpmem_req_in.sv
design/mpmem_bank_sram.sv
design/mpmem_dup_core.sv
design/mpmem_rd_out.sv
design/mpmem_top.sv
tb/mpmem_assert.sv
tb/mpmem_tb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and pass only on the testbench's pass line
verilator --binary --timing --assert --top-module mpmem_tb -f build.f -o mpmem_sim \
  || { echo "Build failed"; exit 1; }
out=$(./obj_dir/mpmem_sim 2>&1)
echo "$out"
echo "$out" | grep -qx "TEST RESULT: PASS" && echo "Run passed" && exit 0 \
  || { echo "Run failed"; exit 1; }
